// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_periph_soc -f sim.f \
	-o tb_periph_soc > build.log 2>&1 \
	&& ./obj_dir/tb_periph_soc > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -qx "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim.f ====
source/soc_pkg.sv
source/bus_fabric.sv
source/gpio_port.sv
source/timer_regs.sv
source/timer_core.sv
source/irq_ctrl.sv
source/periph_soc.sv
testbench/periph_soc_chk.sv
testbench/tb_periph_soc.sv

// ==== source/bus_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_fabric import soc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire bus_req_t          bus_req_i,
	output periph_req_t            port_req_o,
	output periph_req_t            tim_req_o,
	output periph_req_t            intc_req_o,
	input  wire logic [DATA_W-1:0] port_rdata_i,
	input  wire logic [DATA_W-1:0] tim_rdata_i,
	input  wire logic [DATA_W-1:0] intc_rdata_i,
	output logic      [DATA_W-1:0] rdata_o,
	output logic                   rvalid_o
);

	logic              id_sel;   // Region hits
	logic              port_sel;
	logic              tim_sel;
	logic              intc_sel;
	logic [DATA_W-1:0] id_rdata; // ID word, zero unless read
	logic [DATA_W-1:0] rdata_q;
	logic              rvalid_q;

	// Strobes only reach the selected peripheral
	function automatic periph_req_t gate_req(input bus_req_t req, input logic sel);
		periph_req_t r;
		r.rd    = req.rd & sel;
		r.wr    = req.wr & sel;
		r.offs  = req.addr[OFFS_W-1:0]; // Word offset in region
		r.wdata = req.wdata;
		return r;
	endfunction

	assign id_sel   = bus_req_i.addr[ADDR_W-1:OFFS_W] == ID_BASE[ADDR_W-1:OFFS_W];
	assign port_sel = bus_req_i.addr[ADDR_W-1:OFFS_W] == PORT_BASE[ADDR_W-1:OFFS_W];
	assign tim_sel  = bus_req_i.addr[ADDR_W-1:OFFS_W] == TIM_BASE[ADDR_W-1:OFFS_W];
	assign intc_sel = bus_req_i.addr[ADDR_W-1:OFFS_W] == INTC_BASE[ADDR_W-1:OFFS_W];

	assign port_req_o = gate_req(bus_req_i, port_sel);
	assign tim_req_o  = gate_req(bus_req_i, tim_sel);
	assign intc_req_o = gate_req(bus_req_i, intc_sel);

	// Read-only ID block lives here
	always_comb begin
		id_rdata = '0;
		if (bus_req_i.rd && id_sel) begin
			case (bus_req_i.addr[OFFS_W-1:0])
				ID_OFFS_CODE: id_rdata = ID_CODE;
				ID_OFFS_VER:  id_rdata = ID_VERSION;
				ID_OFFS_FCPU: id_rdata = ID_FCPU_KHZ;
				ID_OFFS_EDIT: id_rdata = ID_EDITION;
				default:      id_rdata = '0; // Offsets 4..15 read zero
			endcase
		end
	end

	// Unselected sources drive zero, so a plain OR merges them
	always_ff @(posedge clk) begin
		rdata_q <= id_rdata | port_rdata_i | tim_rdata_i | intc_rdata_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= bus_req_i.rd; // Every read answers, mapped or not
		end
	end

	assign rdata_o  = rdata_q;
	assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== source/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port import soc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire periph_req_t       req_i,
	output logic      [DATA_W-1:0] rdata_o,
	input  wire logic [PORT_W-1:0] port_in_i,
	output logic      [PORT_W-1:0] port_out_o,
	output logic      [PORT_W-1:0] port_oe_o
);

	logic [PORT_W-1:0] out_q; // Output latch
	logic [PORT_W-1:0] oe_q;  // Driver enables, 0 = high impedance
	logic [PORT_W-1:0] in_s1; // First sync stage
	logic [PORT_W-1:0] in_s2; // Stable pin value
	logic [DATA_W-1:0] rword;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_q <= '0;
			oe_q  <= '0; // Pins float after reset
		end else if (req_i.wr) begin
			case (req_i.offs)
				PORT_OUT: out_q <= req_i.wdata[PORT_W-1:0];
				PORT_OE:  oe_q  <= req_i.wdata[PORT_W-1:0];
				default:  ; // PORT_IN and above ignore writes
			endcase
		end
	end

	// Two-flop synchroniser on the pins
	always_ff @(posedge clk) begin
		in_s1 <= port_in_i;
		in_s2 <= in_s1;
	end

	always_comb begin
		case (req_i.offs)
			PORT_OUT: rword = DATA_W'(out_q);
			PORT_OE:  rword = DATA_W'(oe_q);
			PORT_IN:  rword = DATA_W'(in_s2);
			default:  rword = '0;
		endcase
	end

	assign rdata_o    = req_i.rd ? rword : '0; // Zero when not read
	assign port_out_o = out_q;
	assign port_oe_o  = oe_q;

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import soc_pkg::*; (
	input  wire logic         clk,
	input  wire logic         rst_n_i,
	input  wire periph_req_t  req_i,
	input  wire logic [1:0]   ext_irq_i,
	input  wire tim_evt_t     tim_evt_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              irq_o
);

	logic [1:0]         ext_s1;   // Sync stage 1
	logic [1:0]         ext_s2;   // Sync stage 2
	logic [1:0]         ext_s3;   // Previous level for edge detect
	logic [1:0]         ext_rise;
	logic [NUM_IRQ-1:0] src;      // Set requests this cycle
	logic [NUM_IRQ-1:0] clr;      // Write-1-to-clear mask
	logic [NUM_IRQ-1:0] pend_q;
	logic [NUM_IRQ-1:0] en_q;
	logic               irq_q;
	logic [DATA_W-1:0]  vec;
	logic [DATA_W-1:0]  rword;

	always_ff @(posedge clk) begin
		ext_s1 <= ext_irq_i;
		ext_s2 <= ext_s1;
		ext_s3 <= ext_s2;
	end

	assign ext_rise = ext_s2 & ~ext_s3; // Rising edges only

	always_comb begin
		src = '0;
		src[IRQ_EXT0] = ext_rise[0];
		src[IRQ_EXT1] = ext_rise[1];
		src[IRQ_TOVF] = tim_evt_i.ovf;
		src[IRQ_TCMA] = tim_evt_i.cma;
		src[IRQ_TCMB] = tim_evt_i.cmb;
	end

	assign clr = (req_i.wr && req_i.offs == INTC_PEND) ? req_i.wdata[NUM_IRQ-1:0] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pend_q <= '0;
			en_q   <= '0;
			irq_q  <= 1'b0;
		end else begin
			pend_q <= (pend_q & ~clr) | src; // New event beats a clear
			if (req_i.wr && req_i.offs == INTC_EN) begin
				en_q <= req_i.wdata[NUM_IRQ-1:0];
			end
			irq_q <= |(pend_q & en_q);
		end
	end

	// Lowest numbered active source wins, all ones when idle
	always_comb begin
		vec = '1;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (pend_q[i] && en_q[i]) begin
				vec = DATA_W'(i);
			end
		end
	end

	always_comb begin
		case (req_i.offs)
			INTC_PEND: rword = DATA_W'(pend_q);
			INTC_EN:   rword = DATA_W'(en_q);
			INTC_VEC:  rword = vec;
			default:   rword = '0;
		endcase
	end

	assign rdata_o = req_i.rd ? rword : '0;
	assign irq_o   = irq_q;

endmodule

`default_nettype wire

// ==== source/periph_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_soc import soc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire bus_req_t          bus_req_i,
	output logic      [DATA_W-1:0] rdata_o,
	output logic                   rvalid_o,
	input  wire logic [PORT_W-1:0] port_in_i,
	output logic      [PORT_W-1:0] port_out_o,
	output logic      [PORT_W-1:0] port_oe_o,
	input  wire logic [1:0]        ext_irq_i,
	output logic                   pwm_a_o,
	output logic                   pwm_b_o,
	output logic                   irq_o
);

	periph_req_t       port_req;
	periph_req_t       tim_req;
	periph_req_t       intc_req;
	logic [DATA_W-1:0] port_rdata;
	logic [DATA_W-1:0] tim_rdata;
	logic [DATA_W-1:0] intc_rdata;
	tim_cfg_t          tim_cfg;   // Register block to counter
	logic [DATA_W-1:0] tim_count; // Counter back to register block
	tim_evt_t          tim_evt;   // Timer strobes to interrupts

	bus_fabric bus_fabric_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.bus_req_i    (bus_req_i),
		.port_req_o   (port_req),
		.tim_req_o    (tim_req),
		.intc_req_o   (intc_req),
		.port_rdata_i (port_rdata),
		.tim_rdata_i  (tim_rdata),
		.intc_rdata_i (intc_rdata),
		.rdata_o      (rdata_o),
		.rvalid_o     (rvalid_o)
	);

	gpio_port gpio_port_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (port_req),
		.rdata_o    (port_rdata),
		.port_in_i  (port_in_i),
		.port_out_o (port_out_o),
		.port_oe_o  (port_oe_o)
	);

	timer_regs timer_regs_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (tim_req),
		.count_i (tim_count),
		.cfg_o   (tim_cfg),
		.rdata_o (tim_rdata)
	);

	timer_core timer_core_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.cfg_i   (tim_cfg),
		.count_o (tim_count),
		.pwm_a_o (pwm_a_o),
		.pwm_b_o (pwm_b_o),
		.evt_o   (tim_evt)
	);

	irq_ctrl irq_ctrl_inst (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.req_i     (intc_req),
		.ext_irq_i (ext_irq_i),
		.tim_evt_i (tim_evt),
		.rdata_o   (intc_rdata),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// Bus and peripheral widths
	localparam int ADDR_W  = 16;            // Bus address
	localparam int DATA_W  = 16;            // Bus data
	localparam int OFFS_W  = 4;             // Register offset inside a region
	localparam int PORT_W  = 8;             // GPIO pins
	localparam int NUM_IRQ = 5;             // Interrupt sources

	// Region bases, 16 words each, selected by addr[15:4]
	localparam logic [ADDR_W-1:0] ID_BASE   = 16'hff00;
	localparam logic [ADDR_W-1:0] PORT_BASE = 16'hff10;
	localparam logic [ADDR_W-1:0] TIM_BASE  = 16'hff20;
	localparam logic [ADDR_W-1:0] INTC_BASE = 16'hff30;

	// Identification words
	localparam logic [DATA_W-1:0] ID_CODE     = 16'h113a;
	localparam logic [DATA_W-1:0] ID_VERSION  = 16'h0148;
	localparam logic [DATA_W-1:0] ID_FCPU_KHZ = 16'd24000;
	localparam logic [DATA_W-1:0] ID_EDITION  = 16'h4d44; // "MD"

	localparam logic [OFFS_W-1:0] ID_OFFS_CODE = 4'd0;
	localparam logic [OFFS_W-1:0] ID_OFFS_VER  = 4'd1;
	localparam logic [OFFS_W-1:0] ID_OFFS_FCPU = 4'd2;
	localparam logic [OFFS_W-1:0] ID_OFFS_EDIT = 4'd3;

	localparam logic [OFFS_W-1:0] PORT_OUT = 4'd0; // Output latch
	localparam logic [OFFS_W-1:0] PORT_OE  = 4'd1; // Driver enable
	localparam logic [OFFS_W-1:0] PORT_IN  = 4'd2; // Synchronised pins

	localparam logic [OFFS_W-1:0] TIM_PERIOD = 4'd0;
	localparam logic [OFFS_W-1:0] TIM_CMPA   = 4'd1;
	localparam logic [OFFS_W-1:0] TIM_CMPB   = 4'd2;
	localparam logic [OFFS_W-1:0] TIM_CTRL   = 4'd3; // Bit 0 enables
	localparam logic [OFFS_W-1:0] TIM_COUNT  = 4'd4; // Live count, read only

	localparam logic [OFFS_W-1:0] INTC_PEND = 4'd0; // Write 1 to clear
	localparam logic [OFFS_W-1:0] INTC_EN   = 4'd1;
	localparam logic [OFFS_W-1:0] INTC_VEC  = 4'd2; // Lowest active source

	// Interrupt source bit positions
	localparam int IRQ_EXT0 = 0;
	localparam int IRQ_EXT1 = 1;
	localparam int IRQ_TOVF = 2;
	localparam int IRQ_TCMA = 3;
	localparam int IRQ_TCMB = 4;

	typedef struct packed {
		logic              rd;    // One-cycle read strobe
		logic              wr;    // One-cycle write strobe
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic              rd;    // Already qualified by region
		logic              wr;
		logic [OFFS_W-1:0] offs;
		logic [DATA_W-1:0] wdata;
	} periph_req_t;

	typedef struct packed {
		logic              enable;
		logic [DATA_W-1:0] period; // Count wraps after this value
		logic [DATA_W-1:0] cmpa;
		logic [DATA_W-1:0] cmpb;
	} tim_cfg_t;

	typedef struct packed {
		logic ovf; // Wrap strobe
		logic cma; // Count hit cmpa
		logic cmb; // Count hit cmpb
	} tim_evt_t;

endpackage

`default_nettype wire

// ==== source/timer_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_core import soc_pkg::*; (
	input  wire logic         clk,
	input  wire logic         rst_n_i,
	input  wire tim_cfg_t     cfg_i,
	output logic [DATA_W-1:0] count_o,
	output logic              pwm_a_o,
	output logic              pwm_b_o,
	output tim_evt_t          evt_o
);

	logic [DATA_W-1:0] count_q;
	logic              wrap;    // Last count of the period
	logic              pwm_a_q;
	logic              pwm_b_q;
	tim_evt_t          evt_q;

	// >= keeps the count bounded if period is lowered mid-run
	assign wrap = count_q >= cfg_i.period;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q <= '0;
			pwm_a_q <= 1'b0;
			pwm_b_q <= 1'b0;
			evt_q   <= '0;
		end else if (!cfg_i.enable) begin
			count_q <= '0; // Parked at zero, outputs low
			pwm_a_q <= 1'b0;
			pwm_b_q <= 1'b0;
			evt_q   <= '0;
		end else begin
			count_q <= wrap ? '0 : count_q + 1'b1; // 0..period, period+1 cycles
			pwm_a_q <= count_q < cfg_i.cmpa; // High for cmpa counts
			pwm_b_q <= count_q < cfg_i.cmpb;
			evt_q.ovf <= wrap;
			evt_q.cma <= count_q == cfg_i.cmpa;
			evt_q.cmb <= count_q == cfg_i.cmpb;
		end
	end

	assign count_o = count_q;
	assign pwm_a_o = pwm_a_q;
	assign pwm_b_o = pwm_b_q;
	assign evt_o   = evt_q; // Single-cycle strobes

endmodule

`default_nettype wire

// ==== source/timer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_regs import soc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n_i,
	input  wire periph_req_t       req_i,
	input  wire logic [DATA_W-1:0] count_i,
	output tim_cfg_t               cfg_o,
	output logic      [DATA_W-1:0] rdata_o
);

	logic              enable_q;
	logic [DATA_W-1:0] period_q;
	logic [DATA_W-1:0] cmpa_q;
	logic [DATA_W-1:0] cmpb_q;
	logic [DATA_W-1:0] rword;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			enable_q <= 1'b0; // Timer stopped
			period_q <= '0;
			cmpa_q   <= '0;
			cmpb_q   <= '0;
		end else if (req_i.wr) begin
			case (req_i.offs)
				TIM_PERIOD: period_q <= req_i.wdata;
				TIM_CMPA:   cmpa_q   <= req_i.wdata;
				TIM_CMPB:   cmpb_q   <= req_i.wdata;
				TIM_CTRL:   enable_q <= req_i.wdata[0];
				default:    ; // Count is read only
			endcase
		end
	end

	always_comb begin
		case (req_i.offs)
			TIM_PERIOD: rword = period_q;
			TIM_CMPA:   rword = cmpa_q;
			TIM_CMPB:   rword = cmpb_q;
			TIM_CTRL:   rword = DATA_W'(enable_q);
			TIM_COUNT:  rword = count_i; // Live from the core
			default:    rword = '0;
		endcase
	end

	assign rdata_o = req_i.rd ? rword : '0;

	assign cfg_o = '{
		enable: enable_q,
		period: period_q,
		cmpa:   cmpa_q,
		cmpb:   cmpb_q
	};

endmodule

`default_nettype wire

// ==== testbench/periph_soc_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_soc_chk import soc_pkg::*; (
	input wire logic               clk,
	input wire logic               rst_n_i,
	input wire bus_req_t           bus_req_i,
	input wire logic               rvalid_i,
	input wire logic               irq_i,
	input wire logic [NUM_IRQ-1:0] pend_i, // Pending bits inside irq_ctrl
	input wire logic [NUM_IRQ-1:0] en_i    // Enable bits inside irq_ctrl
);

	// Read response exactly one cycle behind each rd strobe
	rvalid_follows_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
		rvalid_i == $past(bus_req_i.rd))
		else $error("rvalid_o out of step with the read strobe");

	no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(bus_req_i.rd && bus_req_i.wr))
		else $error("read and write strobes set together");

	// Registered interrupt needs an enabled pending source one cycle earlier
	irq_has_source: assert property (@(posedge clk) disable iff (!rst_n_i)
		irq_i |-> $past(|(pend_i & en_i)))
		else $error("irq_o high with no enabled pending source");

endmodule

bind periph_soc periph_soc_chk periph_soc_chk_inst (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.bus_req_i (bus_req_i),
	.rvalid_i  (rvalid_o),
	.irq_i     (irq_o),
	.pend_i    (irq_ctrl_inst.pend_q),
	.en_i      (irq_ctrl_inst.en_q)
);

`default_nettype wire

// ==== testbench/tb_periph_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_periph_soc import soc_pkg::*; ();

	localparam int TIMEOUT_CYC = 20000; // Longest timer test is a few hundred cycles

	logic        clk;
	logic        rst_n;
	bus_req_t    bus_req;
	logic [15:0] rdata;
	logic        rvalid;
	logic [7:0]  port_in;
	logic [7:0]  port_out;
	logic [7:0]  port_oe;
	logic [1:0]  ext_irq;
	logic        pwm_a;
	logic        pwm_b;
	logic        irq;
	logic [31:0] lfsr_q;
	int          cycle_cnt;

	periph_soc periph_soc_inst (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.bus_req_i  (bus_req),
		.rdata_o    (rdata),
		.rvalid_o   (rvalid),
		.port_in_i  (port_in),
		.port_out_o (port_out),
		.port_oe_o  (port_oe),
		.ext_irq_i  (ext_irq),
		.pwm_a_o    (pwm_a),
		.pwm_b_o    (pwm_b),
		.irq_o      (irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			abort_run($sformatf("Timeout after %0d cycles, tests did not finish", cycle_cnt));
		end
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v      = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	function automatic logic [15:0] reg_addr(input logic [15:0] base, input logic [3:0] offs);
		return base | 16'(offs);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2; // Drive point
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
		bus_req = '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
		next_cycle();
		bus_req = '0;
	endtask

	// Response registered at the edge that takes the strobe
	task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
		bus_req = '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 16'h0000};
		next_cycle();
		bus_req = '0;
		check_value("rvalid_o", 32'(rvalid), 32'd1);
		data = rdata;
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [15:0] exp,
		input string name);
		logic [15:0] v;
		bus_read(addr, v);
		check_value(name, 32'(v), 32'(exp));
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq !== level && n < limit) begin
			next_cycle();
			n = n + 1;
		end
		check_value("irq_o", 32'(irq), 32'(level));
	endtask

	task automatic test_reset_and_id();
		check_value("rvalid_o", 32'(rvalid), 32'd0);
		check_value("port_out_o", 32'(port_out), 32'd0);
		check_value("port_oe_o", 32'(port_oe), 32'd0); // Pins float
		check_value("pwm_a_o", 32'(pwm_a), 32'd0);
		check_value("pwm_b_o", 32'(pwm_b), 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		read_expect(reg_addr(ID_BASE, 4'd0), 16'h113a, "id_code");
		read_expect(reg_addr(ID_BASE, 4'd1), 16'h0148, "id_version");
		read_expect(reg_addr(ID_BASE, 4'd2), 16'd24000, "id_fcpu_khz");
		read_expect(reg_addr(ID_BASE, 4'd3), 16'h4d44, "id_edition");
		read_expect(reg_addr(ID_BASE, 4'd7), 16'h0000, "id_unused");
		read_expect(16'h4000, 16'h0000, "unmapped");
	endtask

	task automatic test_port();
		logic [7:0] out_v;
		logic [7:0] oe_v;
		logic [7:0] in_v;
		out_v = 8'(lfsr_take(8));
		oe_v  = 8'(lfsr_take(8));
		in_v  = 8'(lfsr_take(8));
		bus_write(reg_addr(PORT_BASE, PORT_OUT), 16'(out_v));
		bus_write(reg_addr(PORT_BASE, PORT_OE), 16'(oe_v));
		check_value("port_out_o", 32'(port_out), 32'(out_v));
		check_value("port_oe_o", 32'(port_oe), 32'(oe_v));
		read_expect(reg_addr(PORT_BASE, PORT_OUT), 16'(out_v), "port_out_reg");
		read_expect(reg_addr(PORT_BASE, PORT_OE), 16'(oe_v), "port_oe_reg");
		port_in = in_v;
		repeat (3) next_cycle(); // Through the synchroniser
		read_expect(reg_addr(PORT_BASE, PORT_IN), 16'(in_v), "port_in_reg");
	endtask

	task automatic test_timer_pwm();
		int period;
		int cmpa;
		int cmpb;
		int hi_a;
		int hi_b;
		int i;
		period = 8 + int'(lfsr_take(6) % 33); // 8..40
		cmpa   = int'(lfsr_take(6)) % (period + 1);
		cmpb   = int'(lfsr_take(6)) % (period + 1);
		bus_write(reg_addr(TIM_BASE, TIM_PERIOD), 16'(period));
		bus_write(reg_addr(TIM_BASE, TIM_CMPA), 16'(cmpa));
		bus_write(reg_addr(TIM_BASE, TIM_CMPB), 16'(cmpb));
		bus_write(reg_addr(TIM_BASE, TIM_CTRL), 16'h0001);
		repeat (period + 1) next_cycle(); // Past the start-up period
		hi_a = 0;
		hi_b = 0;
		for (i = 0; i <= period; i++) begin
			if (pwm_a) hi_a = hi_a + 1;
			if (pwm_b) hi_b = hi_b + 1;
			next_cycle();
		end
		check_value("pwm_a_o high cycles", 32'(hi_a), 32'(cmpa));
		check_value("pwm_b_o high cycles", 32'(hi_b), 32'(cmpb));
		bus_write(reg_addr(TIM_BASE, TIM_CTRL), 16'h0000);
		next_cycle(); // Core sees the stop one edge later
		check_value("pwm_a_o", 32'(pwm_a), 32'd0);
		check_value("pwm_b_o", 32'(pwm_b), 32'd0);
		read_expect(reg_addr(TIM_BASE, TIM_COUNT), 16'h0000, "tim_count");
	endtask

	task automatic test_ext_irq();
		bus_write(reg_addr(INTC_BASE, INTC_PEND), 16'h001f); // Drop leftovers
		bus_write(reg_addr(INTC_BASE, INTC_EN), 16'h0003);
		ext_irq = 2'b10;
		next_cycle();
		ext_irq = 2'b00;
		wait_irq(1'b1, 5); // 6 cycles from the pin rising
		read_expect(reg_addr(INTC_BASE, INTC_PEND), 16'h0002, "intc_pend");
		read_expect(reg_addr(INTC_BASE, INTC_VEC), 16'h0001, "intc_vec");
		bus_write(reg_addr(INTC_BASE, INTC_PEND), 16'h0002);
		wait_irq(1'b0, 2);
		read_expect(reg_addr(INTC_BASE, INTC_VEC), 16'hffff, "intc_vec idle");
	endtask

	task automatic test_timer_irq();
		logic [15:0] pend;
		bus_write(reg_addr(TIM_BASE, TIM_PERIOD), 16'd10);
		bus_write(reg_addr(TIM_BASE, TIM_CMPA), 16'd3);
		bus_write(reg_addr(TIM_BASE, TIM_CMPB), 16'd7);
		bus_write(reg_addr(INTC_BASE, INTC_PEND), 16'h001f);
		bus_write(reg_addr(INTC_BASE, INTC_EN), 16'h0004); // Overflow only
		bus_write(reg_addr(TIM_BASE, TIM_CTRL), 16'h0001);
		wait_irq(1'b1, 15);
		bus_read(reg_addr(INTC_BASE, INTC_PEND), pend);
		check_value("intc_pend ovf", 32'(pend[2]), 32'd1);
		check_value("intc_pend ext", 32'(pend[1:0]), 32'd0); // Only 3 and 4 may join
		bus_write(reg_addr(TIM_BASE, TIM_CTRL), 16'h0000);
		bus_write(reg_addr(INTC_BASE, INTC_EN), 16'h0000);
		next_cycle();
		bus_write(reg_addr(INTC_BASE, INTC_PEND), 16'h001f);
	endtask

	initial begin
		cycle_cnt = 0;
		lfsr_q    = 32'h12d18b97;
		rst_n     = 1'b0;
		bus_req   = '0;
		port_in   = 8'h00;
		ext_irq   = 2'b00;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_cycle();
		test_reset_and_id();
		test_port();
		test_timer_pwm();
		test_ext_irq();
		test_timer_irq();
		repeat (4) next_cycle();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
